/* logic/call_detect.sv */
module call_detect (
  input  ras_pkg::branch_evt_t evt,
  input  logic                 evt_valid,
  output logic                 evt_ready,
  input  logic                 ras_ena,
  output ras_pkg::stack_op_t   op,
  output logic                 op_valid,
  input  logic                 op_ready
);
  import ras_pkg::*;

  logic is_call;
  logic is_ret;

  // Jump-and-link writing ra
  assign is_call = evt.jal && (evt.rd == RA_REG);
  assign is_ret  = (evt.ins == RET_C_JR) || (evt.ins == RET_JALR);

  always_comb begin
    op.push_addr = evt.next_addr;
    op.target    = evt.target;
    if (!ras_ena) begin
      op.kind = OP_NONE;
    end else if (is_call) begin
      op.kind = OP_PUSH;
    end else if (is_ret) begin
      op.kind = OP_POP;
    end else begin
      op.kind = OP_NONE;
    end
  end

  // Other events are consumed without reaching the stack
  assign op_valid  = evt_valid && (op.kind != OP_NONE);
  assign evt_ready = op_ready;

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

  // Index width covers a backing store of up to 64 entries
  localparam int SPILL_AW = 6;
  localparam int DATA_W   = 32;

  typedef logic [SPILL_AW-1:0] spill_addr_t;

  typedef struct packed {
    logic              write;
    logic [DATA_W-1:0] data;
    spill_addr_t       addr;
  } spill_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } spill_rsp_t;

endpackage

/* logic/ras_pkg.sv */
package ras_pkg;

  localparam int ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  // Return encodings c.jr ra and jalr x0, 0(ra)
  localparam logic [31:0] RET_C_JR = 32'h0000_8082;
  localparam logic [31:0] RET_JALR = 32'h0000_8067;
  localparam logic [4:0]  RA_REG   = 5'd1;

  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_PUSH = 2'd1,
    OP_POP  = 2'd2
  } op_kind_t;

  typedef struct packed {
    logic [31:0] ins;
    logic        jal;
    logic [4:0]  rd;
    addr_t       next_addr;
    addr_t       target;
  } branch_evt_t;

  typedef struct packed {
    op_kind_t kind;
    addr_t    push_addr;
    addr_t    target;
  } stack_op_t;

  typedef struct packed {
    addr_t pred_addr;
    addr_t target;
    logic  mismatch;
  } ras_pred_t;

endpackage

/* logic/ras_spill_ctrl.sv */
module ras_spill_ctrl #(
  parameter int DEPTH        = 32,
  parameter int FILL_THRESH  = 24,
  parameter int EMPTY_THRESH = 16,
  parameter int SPILL_DEPTH  = 32
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [$clog2(DEPTH+1)-1:0] count,
  input  ras_pkg::addr_t             bot_data,
  output logic                       bot_take,
  output logic                       bot_put,
  output ras_pkg::addr_t             put_data,
  output logic                       spilled_any,
  output logic                       busy,
  output logic                       overflow,
  input  logic                       push_blocked,
  output mem_pkg::spill_req_t        req,
  output logic                       req_valid,
  input  logic                       req_ready,
  input  mem_pkg::spill_rsp_t        rsp,
  input  logic                       rsp_valid
);
  import mem_pkg::*;

  localparam int CW = $clog2(DEPTH + 1);
  localparam int BW = SPILL_AW + 1;
  localparam logic [CW-1:0] FILL_LIM  = CW'(FILL_THRESH);
  localparam logic [CW-1:0] EMPTY_LIM = CW'(EMPTY_THRESH);
  localparam logic [BW-1:0] BACK_MAX  = BW'(SPILL_DEPTH);

  typedef enum logic [1:0] {
    IDLE,
    SPILL,
    FILL_WAIT
  } state_t;

  state_t        state;
  state_t        state_nxt;
  logic [BW-1:0] bsp;
  logic [BW-1:0] bsp_dec;
  logic          backing_full;
  logic          want_spill;
  logic          want_fill;

  // Backing stack pointer counts spilled entries
  assign bsp_dec      = bsp - 1'b1;
  assign spilled_any  = (bsp != '0);
  assign backing_full = (bsp == BACK_MAX);

  assign want_spill = (count > FILL_LIM) && !backing_full;
  assign want_fill  = (count < EMPTY_LIM) && spilled_any;

  // Held high while a transfer is pending so the stack stays still
  assign busy = (state != IDLE) || want_spill || want_fill;

  // Fill read goes out straight from idle, count is frozen meanwhile
  assign req_valid = (state == SPILL) || ((state == IDLE) && !want_spill && want_fill);
  assign req.write = (state == SPILL);
  assign req.data  = bot_data;
  assign req.addr  = (state == SPILL) ? bsp[SPILL_AW-1:0] : bsp_dec[SPILL_AW-1:0];

  assign bot_take = (state == SPILL) && req_ready;
  assign bot_put  = (state == FILL_WAIT) && rsp_valid;
  assign put_data = rsp.data;

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (want_spill) begin
          state_nxt = SPILL;
        end else if (want_fill && req_ready) begin
          state_nxt = FILL_WAIT;
        end
      end
      SPILL: begin
        if (req_ready) begin
          state_nxt = IDLE;
        end
      end
      FILL_WAIT: begin
        if (rsp_valid) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      bsp      <= '0;
      overflow <= 1'b0;
    end else begin
      state <= state_nxt;
      if (bot_take) begin
        bsp <= bsp + 1'b1;
      end else if (bot_put) begin
        bsp <= bsp_dec;
      end
      if (push_blocked && backing_full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

/* logic/ras_stack.sv */
module ras_stack #(
  parameter int DEPTH = 32
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  ras_pkg::stack_op_t           op,
  input  logic                         op_valid,
  output logic                         op_ready,
  input  logic                         busy,
  output ras_pkg::ras_pred_t           pred,
  output logic                         pred_valid,
  input  logic                         pred_ready,
  output logic [$clog2(DEPTH+1)-1:0]   count,
  output ras_pkg::addr_t               bot_data,
  input  logic                         bot_take,
  input  logic                         bot_put,
  input  ras_pkg::addr_t               put_data,
  input  logic                         spilled_any,
  output logic                         stack_full,
  output logic                         stack_empty
);
  import ras_pkg::*;

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

  addr_t         mem [DEPTH];
  logic [PW-1:0] top_ptr;
  logic [PW-1:0] bot_ptr;
  logic [PW-1:0] top_idx;
  logic [PW-1:0] bot_prev;
  logic          has_top;
  logic          pop_wait;
  logic          accept;
  logic          do_push;
  logic          do_pop;
  logic          wr_en;
  logic [PW-1:0] wr_idx;
  addr_t         wr_data;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    if (p == PW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  function automatic logic [PW-1:0] ptr_dec(input logic [PW-1:0] p);
    if (p == '0) begin
      return PW'(DEPTH - 1);
    end
    return p - 1'b1;
  endfunction

  // top_ptr is the next free slot, bot_ptr the oldest entry
  assign top_idx  = ptr_dec(top_ptr);
  assign bot_prev = ptr_dec(bot_ptr);
  assign has_top  = (count != '0);
  assign bot_data = mem[bot_ptr];

  assign stack_full  = (count == FULL_CNT);
  assign stack_empty = !has_top && !spilled_any;

  // Pop on an empty on-chip stack waits for the refill
  assign pop_wait = (op.kind == OP_POP) && !has_top && spilled_any;
  assign op_ready = !busy && !pop_wait && (!pred_valid || pred_ready);

  assign accept = op_valid && op_ready;
  // A full stack with no spill pending means the backing store is full too
  assign do_push = accept && (op.kind == OP_PUSH) && !stack_full;
  assign do_pop  = accept && (op.kind == OP_POP);

  assign wr_en   = do_push || bot_put;
  assign wr_idx  = bot_put ? bot_prev : top_ptr;
  assign wr_data = bot_put ? put_data : op.push_addr;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      top_ptr <= '0;
      bot_ptr <= '0;
      count   <= '0;
    end else if (do_push) begin
      top_ptr <= ptr_inc(top_ptr);
      count   <= count + 1'b1;
    end else if (do_pop && has_top) begin
      top_ptr <= top_idx;
      count   <= count - 1'b1;
    end else if (bot_take) begin
      bot_ptr <= ptr_inc(bot_ptr);
      count   <= count - 1'b1;
    end else if (bot_put) begin
      bot_ptr <= bot_prev;
      count   <= count + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pred_valid <= 1'b0;
    end else if (do_pop) begin
      pred_valid <= 1'b1;
    end else if (pred_ready) begin
      pred_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) begin
      pred.pred_addr <= has_top ? mem[top_idx] : '0;
      pred.target    <= op.target;
      pred.mismatch  <= !has_top || (mem[top_idx] != op.target);
    end
  end

endmodule

/* logic/ras_top.sv */
module ras_top #(
  parameter int DEPTH        = 32,
  parameter int FILL_THRESH  = 24,
  parameter int EMPTY_THRESH = 16,
  parameter int SPILL_DEPTH  = 32
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 ras_ena,
  input  ras_pkg::branch_evt_t evt,
  input  logic                 evt_valid,
  output logic                 evt_ready,
  output ras_pkg::ras_pred_t   pred,
  output logic                 pred_valid,
  input  logic                 pred_ready,
  output logic                 stack_full,
  output logic                 stack_empty,
  output logic                 overflow
);
  import ras_pkg::*;
  import mem_pkg::*;

  localparam int CW = $clog2(DEPTH + 1);

  stack_op_t     op;
  logic          op_valid;
  logic          op_ready;
  logic          busy;
  logic [CW-1:0] count;
  addr_t         bot_data;
  addr_t         put_data;
  logic          bot_take;
  logic          bot_put;
  logic          spilled_any;
  logic          push_blocked;
  spill_req_t    req;
  logic          req_valid;
  logic          req_ready;
  spill_rsp_t    rsp;
  logic          rsp_valid;

  call_detect u_detect (
    .evt       (evt),
    .evt_valid (evt_valid),
    .evt_ready (evt_ready),
    .ras_ena   (ras_ena),
    .op        (op),
    .op_valid  (op_valid),
    .op_ready  (op_ready)
  );

  ras_stack #(
    .DEPTH (DEPTH)
  ) u_stack (
    .clk         (clk),
    .arst_n      (arst_n),
    .op          (op),
    .op_valid    (op_valid),
    .op_ready    (op_ready),
    .busy        (busy),
    .pred        (pred),
    .pred_valid  (pred_valid),
    .pred_ready  (pred_ready),
    .count       (count),
    .bot_data    (bot_data),
    .bot_take    (bot_take),
    .bot_put     (bot_put),
    .put_data    (put_data),
    .spilled_any (spilled_any),
    .stack_full  (stack_full),
    .stack_empty (stack_empty)
  );

  // Accepted push dropped on a full on-chip stack
  assign push_blocked = op_valid && op_ready && (op.kind == OP_PUSH) && stack_full;

  ras_spill_ctrl #(
    .DEPTH        (DEPTH),
    .FILL_THRESH  (FILL_THRESH),
    .EMPTY_THRESH (EMPTY_THRESH),
    .SPILL_DEPTH  (SPILL_DEPTH)
  ) u_spill_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .count        (count),
    .bot_data     (bot_data),
    .bot_take     (bot_take),
    .bot_put      (bot_put),
    .put_data     (put_data),
    .spilled_any  (spilled_any),
    .busy         (busy),
    .overflow     (overflow),
    .push_blocked (push_blocked),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .rsp          (rsp),
    .rsp_valid    (rsp_valid)
  );

  spill_ram #(
    .SPILL_DEPTH (SPILL_DEPTH)
  ) u_spill_ram (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

endmodule

/* logic/spill_ram.sv */
module spill_ram #(
  parameter int SPILL_DEPTH = 32
) (
  input  logic                clk,
  input  logic                arst_n,
  input  mem_pkg::spill_req_t req,
  input  logic                req_valid,
  output logic                req_ready,
  output mem_pkg::spill_rsp_t rsp,
  output logic                rsp_valid
);
  import mem_pkg::*;

  localparam int AW = $clog2(SPILL_DEPTH);

  logic [DATA_W-1:0] mem [SPILL_DEPTH];
  logic [AW-1:0]     idx;
  logic              rd_en;

  assign req_ready = 1'b1;
  assign idx       = req.addr[AW-1:0];
  assign rd_en     = req_valid && !req.write;

  always_ff @(posedge clk) begin
    if (req_valid && req.write) begin
      mem[idx] <= req.data;
    end
    if (rd_en) begin
      rsp.data <= mem[idx];
    end
  end

  // Read data arrives one cycle after the request
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_en;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module ras_tb -f src.f -o ras_tb_sim \
  && ./obj_dir/ras_tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "No pass line found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

/* src.f */
logic/ras_pkg.sv
logic/mem_pkg.sv
logic/call_detect.sv
logic/ras_stack.sv
logic/ras_spill_ctrl.sv
logic/spill_ram.sv
logic/ras_top.sv
testbench/ras_tb.sv

/* testbench/ras_tb.sv */
module ras_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ras_pkg::*;

  // Stack capacity is on-chip plus backing entries
  localparam int CAP = 8 + 16;
  // Events sent over all tests
  localparam int EVT_COUNT = 106;

  logic        clk;
  logic        arst_n;
  logic        ras_ena;
  branch_evt_t evt;
  logic        evt_valid;
  logic        evt_ready;
  ras_pred_t   pred;
  logic        pred_valid;
  logic        pred_ready;
  logic        stack_full;
  logic        stack_empty;
  logic        overflow;

  addr_t       model_q[$];
  logic [31:0] rng_state;

  ras_top #(
    .DEPTH        (8),
    .FILL_THRESH  (6),
    .EMPTY_THRESH (2),
    .SPILL_DEPTH  (16)
  ) u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .ras_ena     (ras_ena),
    .evt         (evt),
    .evt_valid   (evt_valid),
    .evt_ready   (evt_ready),
    .pred        (pred),
    .pred_valid  (pred_valid),
    .pred_ready  (pred_ready),
    .stack_full  (stack_full),
    .stack_empty (stack_empty),
    .overflow    (overflow)
  );

  always #10 clk = ~clk;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "Stopped at first error");
    end
  endtask

  function automatic addr_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[31:2], 2'b00};
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_evt(input logic [31:0] ins, input logic jal, input logic [4:0] rd,
                          input addr_t next_addr, input addr_t target);
    evt.ins       = ins;
    evt.jal       = jal;
    evt.rd        = rd;
    evt.next_addr = next_addr;
    evt.target    = target;
    evt_valid     = 1'b1;
    #1;
    while (!evt_ready) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    evt_valid = 1'b0;
  endtask

  task automatic expect_pred(input addr_t exp_addr, input addr_t exp_target, input logic exp_mis);
    while (!pred_valid) begin
      @(negedge clk);
    end
    compare("pred.pred_addr", pred.pred_addr, exp_addr);
    compare("pred.target", pred.target, exp_target);
    compare("pred.mismatch", 32'(pred.mismatch), 32'(exp_mis));
  endtask

  // jal ra pushes its return address
  task automatic push_call(input addr_t ret_addr);
    send_evt(32'h0000_00ef, 1'b1, 5'd1, ret_addr, ret_addr + 32'h0000_0400);
    if (model_q.size() < CAP) begin
      model_q.push_back(ret_addr);
    end
  endtask

  task automatic pop_return(input addr_t target);
    addr_t exp_addr;
    logic  exp_mis;
    if (model_q.size() == 0) begin
      exp_addr = '0;
      exp_mis  = 1'b1;
    end else begin
      exp_addr = model_q.pop_back();
      exp_mis  = (exp_addr != target);
    end
    send_evt(32'h0000_8082, 1'b0, 5'd0, target + 32'd2, target);
    expect_pred(exp_addr, target, exp_mis);
  endtask

  task automatic reset_and_empty_pop();
    compare("stack_empty", 32'(stack_empty), 32'd1);
    compare("stack_full", 32'(stack_full), 32'd0);
    compare("overflow", 32'(overflow), 32'd0);
    compare("pred_valid", 32'(pred_valid), 32'd0);
    compare("evt_ready", 32'(evt_ready), 32'd1);
    pop_return(32'h0000_1234);
  endtask

  task automatic call_return_pair();
    addr_t a;
    a = next_rand();
    push_call(a);
    compare("stack_empty", 32'(stack_empty), 32'd0);
    pop_return(a);
    a = next_rand();
    push_call(a);
    pop_return(a ^ 32'h0000_0010);
  endtask

  task automatic nested_spill_fill();
    addr_t addrs[20];
    for (int i = 0; i < 20; i++) begin
      addrs[i] = next_rand();
      push_call(addrs[i]);
    end
    compare("stack_empty", 32'(stack_empty), 32'd0);
    for (int i = 19; i >= 0; i--) begin
      pop_return(addrs[i]);
    end
    compare("stack_empty", 32'(stack_empty), 32'd1);
  endtask

  task automatic ignored_events();
    addr_t a;
    a = next_rand();
    push_call(a);
    // Plain jump, link to another register, conditional branch
    send_evt(32'h0000_006f, 1'b1, 5'd0, 32'h0000_2004, 32'h0000_3000);
    send_evt(32'h0000_02ef, 1'b1, 5'd5, 32'h0000_2008, 32'h0000_3100);
    send_evt(32'h0000_0063, 1'b0, 5'd0, 32'h0000_200c, 32'h0000_3200);
    ras_ena = 1'b0;
    send_evt(32'h0000_00ef, 1'b1, 5'd1, 32'h0000_2010, 32'h0000_3300);
    send_evt(32'h0000_8082, 1'b0, 5'd0, 32'h0000_2012, 32'h0000_3400);
    compare("pred_valid", 32'(pred_valid), 32'd0);
    ras_ena = 1'b1;
    pop_return(a);
  endtask

  task automatic pred_backpressure();
    addr_t a;
    a = next_rand();
    push_call(a);
    pred_ready = 1'b0;
    pop_return(a);
    repeat (5) begin
      @(negedge clk);
      compare("pred_valid", 32'(pred_valid), 32'd1);
      compare("pred.pred_addr", pred.pred_addr, a);
      compare("evt_ready", 32'(evt_ready), 32'd0);
    end
    pred_ready = 1'b1;
    @(negedge clk);
    compare("pred_valid", 32'(pred_valid), 32'd0);
    compare("evt_ready", 32'(evt_ready), 32'd1);
    a = next_rand();
    push_call(a);
    pop_return(a);
  endtask

  task automatic overflow_drain();
    addr_t addrs[25];
    for (int i = 0; i < 24; i++) begin
      addrs[i] = next_rand();
      push_call(addrs[i]);
    end
    compare("stack_full", 32'(stack_full), 32'd1);
    compare("overflow", 32'(overflow), 32'd0);
    // One push past capacity is dropped
    addrs[24] = next_rand();
    push_call(addrs[24]);
    compare("overflow", 32'(overflow), 32'd1);
    for (int i = 23; i >= 0; i--) begin
      pop_return(addrs[i]);
    end
    pop_return(addrs[24]);
    compare("stack_empty", 32'(stack_empty), 32'd1);
    compare("overflow", 32'(overflow), 32'd1);
  endtask

  // Budget per event sent plus reset and margin
  initial begin
    repeat (EVT_COUNT * 200 + 1000) @(posedge clk);
    $display("Timeout, the DUT stopped handshaking");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    ras_ena    = 1'b1;
    evt        = '0;
    evt_valid  = 1'b0;
    pred_ready = 1'b1;
    rng_state  = 32'h60d0_e105;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    reset_and_empty_pop();
    call_return_pair();
    nested_spill_fill();
    ignored_events();
    pred_backpressure();
    overflow_drain();
    $display("Test passed");
    $finish;
  end

endmodule
